// ==== csr_chk.sv ====
`timescale 1ns/1ps

// handshake and timing rules of csr_top, attached to every instance by bind.
module csr_chk (
   input logic i_clk,
   input logic i_reset,
   input logic i_valid,
   input logic i_ready,
   input logic i_done,
   input logic i_new_irq
);
   // number of assertion failures so far.
   int   fail_cnt = 0;
   logic accept;

   // a command is taken on an edge where valid and ready are both high.
   assign accept = i_valid & i_ready;

   done_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
      i_done |=> !i_done)
   else begin
      $error("o_done stayed high for a second cycle");
      fail_cnt++;
   end

   // done follows acceptance after exactly 33 cycles, in both directions.
   done_after_accept: assert property (@(posedge i_clk) disable iff (i_reset)
      $past(accept, 33) |-> i_done)
   else begin
      $error("o_done missing 33 cycles after acceptance");
      fail_cnt++;
   end

   accept_before_done: assert property (@(posedge i_clk) disable iff (i_reset)
      i_done |-> $past(accept, 33))
   else begin
      $error("o_done without an acceptance 33 cycles earlier");
      fail_cnt++;
   end

   // ready drops after acceptance and may only rise once done has been shown.
   ready_drop: assert property (@(posedge i_clk) disable iff (i_reset)
      accept |=> !i_ready)
   else begin
      $error("o_ready still high after acceptance");
      fail_cnt++;
   end

   ready_hold: assert property (@(posedge i_clk) disable iff (i_reset)
      (!i_ready && !i_done) |=> !i_ready)
   else begin
      $error("o_ready rose before o_done");
      fail_cnt++;
   end

   ready_low_at_done: assert property (@(posedge i_clk) disable iff (i_reset)
      i_done |-> !i_ready)
   else begin
      $error("o_ready high together with o_done");
      fail_cnt++;
   end

   irq_single: assert property (@(posedge i_clk) disable iff (i_reset)
      i_new_irq |=> !i_new_irq)
   else begin
      $error("o_new_irq high on two consecutive cycles");
      fail_cnt++;
   end

   // the first cycle out of reset shows an idle block.
   reset_state: assert property (@(posedge i_clk)
      $fell(i_reset) |-> (i_ready && !i_done && !i_new_irq))
   else begin
      $error("outputs not idle in the first cycle after reset");
      fail_cnt++;
   end
endmodule

bind csr_top csr_chk u_chk (
   .i_clk     (i_clk),
   .i_reset   (i_reset),
   .i_valid   (i_valid),
   .i_ready   (o_ready),
   .i_done    (o_done),
   .i_new_irq (o_new_irq)
);

// ==== csr_pkg.sv ====
package csr_pkg;

   // width of every machine-mode register handled by the block.
   localparam int CSR_W = 32;

   typedef logic [CSR_W-1:0] csr_word_t;

   // index of the bit currently on the serial path, 0 to 31.
   typedef logic [4:0] bit_cnt_t;

   // registers that an access command can address.
   typedef enum logic [2:0] {
      SEL_MSTATUS, SEL_MIE, SEL_MCAUSE, SEL_MSCRATCH, SEL_MTVEC, SEL_MEPC, SEL_MTVAL
   } csr_sel_t;

   // read keeps the value, write replaces it, set ORs and clear masks with the operand.
   typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_SET, OP_CLR} csr_op_t;

   typedef enum logic [1:0] {CMD_ACCESS, CMD_TRAP, CMD_MRET} cmd_kind_t;

   // the mcause code stored for each cause is fixed by the serial recurrence in csr_state.
   typedef enum logic [2:0] {
      CAUSE_TIMER_IRQ,
      CAUSE_EBREAK,
      CAUSE_ECALL,
      CAUSE_LOAD_MISALIGN,
      CAUSE_STORE_MISALIGN,
      CAUSE_JUMP_MISALIGN
   } trap_cause_t;

   typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} seq_state_t;

endpackage

// ==== csr_scratch_regs.sv ====
`timescale 1ns/1ps

module csr_scratch_regs (
   input  logic   i_clk,
   input  logic   i_reset,
   input  logic   i_csr_in,
   csr_ser_if.blk ser,
   output logic   o_rf_out
);
   import csr_pkg::*;

   // mscratch, mtvec, mepc and mtval in selector order.
   csr_word_t  regs [4];
   logic       hit;
   logic [1:0] idx;

   // only the four full-width registers live here.
   assign hit = ser.en & ((ser.sel == SEL_MSCRATCH) |
                          (ser.sel == SEL_MTVEC) |
                          (ser.sel == SEL_MEPC) |
                          (ser.sel == SEL_MTVAL));

   // the selectors are consecutive, so the offset from mscratch picks the entry.
   assign idx = 2'(ser.sel - SEL_MSCRATCH);

   // each access cycle rotates the addressed register right by one.
   // bit 0 leaves as the old value and the new bit enters at the top.
   // after 32 cycles the register holds the updated word in place.
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         for (int i = 0; i < 4; i++) begin
            regs[i] <= '0;
         end
      end else if (hit) begin
         regs[idx] <= {i_csr_in, regs[idx][CSR_W-1:1]};
      end
   end

   // the read bit is forced low when another register is addressed.
   assign o_rf_out = hit & regs[idx][0];
endmodule

// ==== csr_sequencer.sv ====
`timescale 1ns/1ps

module csr_sequencer (
   input  logic                 i_clk,
   input  logic                 i_reset,
   input  logic                 i_valid,
   input  csr_pkg::cmd_kind_t   i_cmd,
   input  csr_pkg::csr_sel_t    i_sel,
   input  csr_pkg::csr_op_t     i_op,
   input  csr_pkg::trap_cause_t i_cause,
   input  csr_pkg::csr_word_t   i_wdata,
   input  logic                 i_q,
   output logic                 o_ready,
   output logic                 o_done,
   output csr_pkg::csr_word_t   o_rdata,
   output logic                 o_d,
   output csr_pkg::csr_op_t     o_op,
   csr_ser_if.seq               ser
);
   import csr_pkg::*;

   seq_state_t  state;
   bit_cnt_t    cnt;
   cmd_kind_t   cmd_r;
   csr_sel_t    sel_r;
   csr_op_t     op_r;
   trap_cause_t cause_r;
   csr_word_t   wdata_sr;
   csr_word_t   res_sr;
   csr_word_t   rdata_r;
   logic        accept;
   logic        run;
   logic        last_bit;
   logic        is_trap;

   // a command is only taken while the machine sits in idle.
   assign o_ready  = (state == S_IDLE);
   assign accept   = i_valid & o_ready;
   assign run      = (state == S_RUN);
   assign last_bit = run & (&cnt);
   assign o_done   = (state == S_DONE);

   // idle, then 32 bit cycles in run, then a single done cycle.
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state <= S_IDLE;
         cnt   <= '0;
         cmd_r <= CMD_ACCESS;
      end else begin
         case (state)
            S_IDLE: begin
               cnt <= '0;
               if (accept) begin
                  state <= S_RUN;
                  cmd_r <= i_cmd;
               end
            end
            S_RUN: begin
               cnt <= cnt + 5'd1;
               // bit 31 is the last one, so the next cycle presents the result.
               if (last_bit) begin
                  state <= S_DONE;
               end
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // the operand leaves lsb first and the old value comes back lsb first.
   always_ff @(posedge i_clk) begin
      if (accept) begin
         sel_r    <= i_sel;
         op_r     <= i_op;
         cause_r  <= i_cause;
         wdata_sr <= i_wdata;
      end else if (run) begin
         wdata_sr <= {1'b0, wdata_sr[CSR_W-1:1]};
         res_sr   <= {i_q, res_sr[CSR_W-1:1]};
      end
      // the word is copied out once, so it holds until the next command ends.
      if (last_bit) begin
         rdata_r <= {i_q, res_sr[CSR_W-1:1]};
      end
   end

   assign o_rdata = rdata_r;
   assign o_d     = wdata_sr[0];
   assign o_op    = op_r;

   // strobes for the register blocks, all qualified by the run state.
   assign is_trap      = run & (cmd_r == CMD_TRAP);
   assign ser.en       = run & (cmd_r == CMD_ACCESS);
   assign ser.cnt0to3  = run & (cnt[4:2] == 3'd0);
   assign ser.cnt3     = run & (cnt == 5'd3);
   assign ser.cnt7     = run & (cnt == 5'd7);
   assign ser.cnt_done = last_bit;
   assign ser.trap     = is_trap;
   assign ser.mret     = run & (cmd_r == CMD_MRET);
   assign ser.sel      = sel_r;

   // the cause is decoded into the flags that drive the mcause truth table.
   assign ser.pending_irq = is_trap & (cause_r == CAUSE_TIMER_IRQ);
   assign ser.ebreak      = is_trap & (cause_r == CAUSE_EBREAK);
   assign ser.e_op        = is_trap & ((cause_r == CAUSE_EBREAK) | (cause_r == CAUSE_ECALL));
   assign ser.mem_cmd     = is_trap & (cause_r == CAUSE_STORE_MISALIGN);
   assign ser.mem_op      = is_trap & ((cause_r == CAUSE_LOAD_MISALIGN) |
                                       (cause_r == CAUSE_STORE_MISALIGN));
endmodule

// ==== csr_ser_if.sv ====
`timescale 1ns/1ps

// per-bit strobes that the sequencer hands to the register blocks.
interface csr_ser_if;
   import csr_pkg::*;

   // en is high while a bit of an access command is on the serial path.
   logic     en;
   logic     cnt0to3;
   logic     cnt3;
   logic     cnt7;
   logic     cnt_done;
   // trap and mret stay high for the whole 32-cycle run of those commands.
   logic     trap;
   logic     mret;
   // cause flags are only high during a trap run.
   logic     pending_irq;
   logic     e_op;
   logic     ebreak;
   logic     mem_op;
   logic     mem_cmd;
   csr_sel_t sel;

   modport seq (output en, cnt0to3, cnt3, cnt7, cnt_done, trap, mret,
                output pending_irq, e_op, ebreak, mem_op, mem_cmd, sel);
   modport blk (input en, cnt0to3, cnt3, cnt7, cnt_done, trap, mret,
                input pending_irq, e_op, ebreak, mem_op, mem_cmd, sel);
endinterface

// ==== csr_state.sv ====
`timescale 1ns/1ps

module csr_state (
   input  logic             i_clk,
   input  logic             i_reset,
   input  logic             i_mtip,
   input  logic             i_d,
   input  logic             i_rf_out,
   input  csr_pkg::csr_op_t i_op,
   csr_ser_if.blk           ser,
   output logic             o_q,
   output logic             o_csr_in,
   output logic             o_new_irq
);
   import csr_pkg::*;

   logic       mstatus_mie;
   logic       mstatus_mpie;
   logic       mie_mtie;
   logic       mcause31;
   logic [3:0] mcause3_0;
   logic       mstatus_en;
   logic       mie_en;
   logic       mcause_en;
   logic       mcause_bit;
   logic       q;
   logic       csr_in;
   logic       timer_irq;
   logic       timer_irq_r;
   logic       new_irq_r;

   // per-register enables, only valid while an access bit is in flight.
   assign mstatus_en = ser.en & (ser.sel == SEL_MSTATUS);
   assign mie_en     = ser.en & (ser.sel == SEL_MIE);
   assign mcause_en  = ser.en & (ser.sel == SEL_MCAUSE);

   // the low code nibble shifts out during bits 0..3, the interrupt flag at bit 31.
   assign mcause_bit = ser.cnt0to3 ? mcause3_0[0] : (ser.cnt_done & mcause31);

   // old value of the addressed register, one bit per cycle.
   // every bit that is not implemented here reads as zero, and rf_out fills the rest.
   assign q = (mstatus_en & ser.cnt3 & mstatus_mie) |
              (mie_en & ser.cnt7 & mie_mtie) |
              (mcause_en & mcause_bit) |
              i_rf_out;

   always_comb begin
      case (i_op)
         OP_WRITE: csr_in = i_d;
         OP_SET:   csr_in = q | i_d;
         OP_CLR:   csr_in = q & ~i_d;
         default:  csr_in = q;
      endcase
   end

   assign o_q      = q;
   assign o_csr_in = csr_in;

   assign timer_irq = i_mtip & mstatus_mie & mie_mtie;
   assign o_new_irq = new_irq_r;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
         mie_mtie     <= 1'b0;
         mcause31     <= 1'b0;
         mcause3_0    <= 4'd0;
         timer_irq_r  <= 1'b0;
         new_irq_r    <= 1'b0;
      end else begin
         // the pulse follows the first cycle in which all three conditions hold.
         timer_irq_r <= timer_irq;
         new_irq_r   <= timer_irq & ~timer_irq_r;

         if (mie_en & ser.cnt7) begin
            mie_mtie <= csr_in;
         end

         // trap clears mie, mret restores it and an mstatus access writes bit 3.
         // only one of the three can be active at a time.
         if ((ser.trap & ser.cnt_done) | (mstatus_en & ser.cnt3) | ser.mret) begin
            mstatus_mie <= ~ser.trap & (ser.mret ? mstatus_mpie : csr_in);
         end
         // mpie keeps the previous mie across a trap and has no software access.
         if (ser.trap & ser.cnt_done) begin
            mstatus_mpie <= mstatus_mie;
         end

         // an access shifts the code nibble, a trap loads it in one step.
         // the trap terms give 7 for the timer, 3 and 11 for ebreak and ecall,
         // 4 and 6 for load and store misalignment and 0 for a jump.
         if ((mcause_en & ser.cnt0to3) | (ser.trap & ser.cnt_done)) begin
            mcause3_0[3] <= (ser.e_op & ~ser.ebreak) | (~ser.trap & csr_in);
            mcause3_0[2] <= ser.pending_irq | ser.mem_op | (~ser.trap & mcause3_0[3]);
            mcause3_0[1] <= ser.pending_irq | ser.e_op | (ser.mem_op & ser.mem_cmd) |
                            (~ser.trap & mcause3_0[2]);
            mcause3_0[0] <= ser.pending_irq | ser.e_op | (~ser.trap & mcause3_0[1]);
         end
         if ((mcause_en & ser.cnt_done) | ser.trap) begin
            mcause31 <= ser.trap ? ser.pending_irq : csr_in;
         end
      end
   end
endmodule

// ==== csr_top.sv ====
`timescale 1ns/1ps

module csr_top (
   input  logic                 i_clk,
   input  logic                 i_reset,
   input  logic                 i_valid,
   input  csr_pkg::cmd_kind_t   i_cmd,
   input  csr_pkg::csr_sel_t    i_sel,
   input  csr_pkg::csr_op_t     i_op,
   input  csr_pkg::trap_cause_t i_cause,
   input  csr_pkg::csr_word_t   i_wdata,
   input  logic                 i_mtip,
   output logic                 o_ready,
   output logic                 o_done,
   output csr_pkg::csr_word_t   o_rdata,
   output logic                 o_new_irq
);
   import csr_pkg::*;

   csr_ser_if ser ();

   // serial data path between the three blocks.
   logic    d;
   logic    q;
   logic    rf_out;
   logic    csr_in;
   csr_op_t op;

   csr_sequencer u_seq (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_valid (i_valid),
      .i_cmd   (i_cmd),
      .i_sel   (i_sel),
      .i_op    (i_op),
      .i_cause (i_cause),
      .i_wdata (i_wdata),
      .i_q     (q),
      .o_ready (o_ready),
      .o_done  (o_done),
      .o_rdata (o_rdata),
      .o_d     (d),
      .o_op    (op),
      .ser     (ser.seq)
   );

   // the state block merges the scratch read bit into q and forms csr_in.
   csr_state u_state (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_mtip    (i_mtip),
      .i_d       (d),
      .i_rf_out  (rf_out),
      .i_op      (op),
      .ser       (ser.blk),
      .o_q       (q),
      .o_csr_in  (csr_in),
      .o_new_irq (o_new_irq)
   );

   csr_scratch_regs u_regs (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_csr_in (csr_in),
      .ser      (ser.blk),
      .o_rf_out (rf_out)
   );
endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the csr testbench with verilator, runs it and checks the verdict line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_csr -f sources.f \
   --Mdir obj_dir -o sim_csr \
   && ./obj_dir/sim_csr +verilator+error+limit+1000 | tee /dev/stderr \
   | grep -q "^Done: no errors$" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
csr_pkg.sv
csr_ser_if.sv
csr_sequencer.sv
csr_state.sv
csr_scratch_regs.sv
csr_top.sv
csr_chk.sv
tb_csr.sv

// ==== tb_csr.sv ====
`timescale 1ns/1ps

module tb_csr;
   import csr_pkg::*;

   logic        i_clk;
   logic        i_reset;
   logic        i_valid;
   cmd_kind_t   i_cmd;
   csr_sel_t    i_sel;
   csr_op_t     i_op;
   trap_cause_t i_cause;
   csr_word_t   i_wdata;
   logic        i_mtip;
   logic        o_ready;
   logic        o_done;
   csr_word_t   o_rdata;
   logic        o_new_irq;

   // reference model of the visible register bits.
   csr_word_t   m_scratch [4];
   logic        m_mie;
   logic        m_mpie;
   logic        m_mtie;
   logic        m_irq;
   logic [3:0]  m_code;

   logic [31:0] lfsr;
   logic        hold_valid;
   int          data_err;
   int          timeouts;
   int          irq_cnt = 0;

   csr_top u_dut (.*);

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   // pulses are counted at the falling edge, where o_new_irq is stable.
   always @(negedge i_clk) begin
      if (o_new_irq) begin
         irq_cnt++;
      end
   end

   // fibonacci lfsr with taps 32, 22, 2 and 1, one step per bit taken.
   function automatic csr_word_t rand_bits(input int n);
      csr_word_t v;
      logic      fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[CSR_W-2:0], fb};
      end
      return v;
   endfunction

   function automatic csr_word_t apply_op(input csr_op_t op, input csr_word_t old,
                                          input csr_word_t d);
      case (op)
         OP_WRITE: return d;
         OP_SET:   return old | d;
         OP_CLR:   return old & ~d;
         default:  return old;
      endcase
   endfunction

   // mstatus shows MIE at bit 3, mie shows MTIE at bit 7, mcause the code and bit 31.
   function automatic csr_word_t model_read(input csr_sel_t sel);
      csr_word_t  v;
      logic [1:0] idx;
      v   = '0;
      idx = 2'(sel - SEL_MSCRATCH);
      case (sel)
         SEL_MSTATUS: v[3] = m_mie;
         SEL_MIE:     v[7] = m_mtie;
         SEL_MCAUSE:  v = {m_irq, 27'd0, m_code};
         default:     v = m_scratch[idx];
      endcase
      return v;
   endfunction

   function automatic void model_write(input csr_sel_t sel, input csr_word_t v);
      logic [1:0] idx;
      idx = 2'(sel - SEL_MSCRATCH);
      case (sel)
         SEL_MSTATUS: m_mie = v[3];
         SEL_MIE:     m_mtie = v[7];
         SEL_MCAUSE: begin
            m_code = v[3:0];
            m_irq  = v[31];
         end
         default:     m_scratch[idx] = v;
      endcase
   endfunction

   // interrupt flag followed by the 4-bit exception code of each cause.
   function automatic logic [4:0] cause_value(input trap_cause_t cause);
      case (cause)
         CAUSE_TIMER_IRQ:      return {1'b1, 4'd7};
         CAUSE_EBREAK:         return {1'b0, 4'd3};
         CAUSE_ECALL:          return {1'b0, 4'd11};
         CAUSE_LOAD_MISALIGN:  return {1'b0, 4'd4};
         CAUSE_STORE_MISALIGN: return {1'b0, 4'd6};
         default:              return {1'b0, 4'd0};
      endcase
   endfunction

   task automatic end_run();
      int chk_err;
      chk_err = u_dut.u_chk.fail_cnt;
      $display("errors: data %0d, assertion %0d, timeout %0d", data_err, chk_err, timeouts);
      if (data_err + chk_err + timeouts == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   // every wait starts and ends 1 ns after a rising edge.
   task automatic wait_ready();
      int cycles;
      cycles = 0;
      while (!o_ready && cycles < 100) begin
         @(posedge i_clk);
         #1;
         cycles++;
      end
      if (!o_ready) begin
         $display("timeout: o_ready did not return within 100 cycles");
         timeouts++;
      end
   endtask

   task automatic wait_done();
      int cycles;
      cycles = 0;
      while (!o_done && cycles < 100) begin
         @(posedge i_clk);
         #1;
         cycles++;
      end
      if (!o_done) begin
         $display("timeout: o_done did not arrive within 100 cycles");
         timeouts++;
      end
   endtask

   // with hold_valid set, i_valid stays high while the block is busy.
   task automatic issue(input cmd_kind_t cmd, input csr_sel_t sel, input csr_op_t op,
                        input trap_cause_t cause, input csr_word_t wdata,
                        input csr_word_t exp);
      if (timeouts == 0) begin
         i_cmd   = cmd;
         i_sel   = sel;
         i_op    = op;
         i_cause = cause;
         i_wdata = wdata;
         i_valid = 1'b1;
         wait_ready();
      end
      if (timeouts == 0) begin
         @(posedge i_clk);
         #1;
         i_valid = hold_valid;
         wait_done();
      end
      if (timeouts == 0) begin
         assert (o_rdata == exp) else begin
            $display("[ERROR] o_rdata expected %h got %h", exp, o_rdata);
            data_err++;
         end
      end
   endtask

   task automatic access(input csr_sel_t sel, input csr_op_t op, input csr_word_t wdata);
      csr_word_t old;
      old = model_read(sel);
      model_write(sel, apply_op(op, old, wdata));
      issue(CMD_ACCESS, sel, op, CAUSE_JUMP_MISALIGN, wdata, old);
   endtask

   // trap and mret return zero data.
   task automatic trap(input trap_cause_t cause);
      m_mpie = m_mie;
      m_mie  = 1'b0;
      {m_irq, m_code} = cause_value(cause);
      issue(CMD_TRAP, SEL_MSTATUS, OP_READ, cause, '0, '0);
   endtask

   task automatic mret();
      m_mie = m_mpie;
      issue(CMD_MRET, SEL_MSTATUS, OP_READ, CAUSE_JUMP_MISALIGN, '0, '0);
   endtask

   task automatic check_irq(input int cycles, input int exp_pulses);
      int start;
      start = irq_cnt;
      repeat (cycles) @(posedge i_clk);
      #1;
      if (timeouts == 0) begin
         assert (irq_cnt - start == exp_pulses) else begin
            $display("[ERROR] o_new_irq pulses expected %h got %h", exp_pulses,
                     irq_cnt - start);
            data_err++;
         end
      end
   endtask

   initial begin
      csr_word_t r;
      csr_sel_t  sel;
      csr_op_t   op;
      i_reset    = 1'b1;
      i_valid    = 1'b0;
      i_cmd      = CMD_ACCESS;
      i_sel      = SEL_MSTATUS;
      i_op       = OP_READ;
      i_cause    = CAUSE_TIMER_IRQ;
      i_wdata    = '0;
      i_mtip     = 1'b0;
      lfsr       = 32'h3f94038b;
      hold_valid = 1'b0;
      data_err   = 0;
      timeouts   = 0;
      m_mie      = 1'b0;
      m_mpie     = 1'b0;
      m_mtie     = 1'b0;
      m_irq      = 1'b0;
      m_code     = 4'd0;
      for (int i = 0; i < 4; i++) begin
         m_scratch[i] = '0;
      end
      repeat (3) @(posedge i_clk);
      #1;
      i_reset = 1'b0;

      // random operations on the four scratch registers, each followed by a read.
      for (int n = 0; n < 24; n++) begin
         r   = rand_bits(2);
         sel = csr_sel_t'({1'b0, r[1:0]} + 3'd3);
         r   = rand_bits(2);
         op  = csr_op_t'(r[1:0]);
         access(sel, op, rand_bits(32));
         access(sel, OP_READ, rand_bits(32));
      end

      // all-ones writes only leave the implemented bits visible.
      access(SEL_MSTATUS, OP_WRITE, '1);
      access(SEL_MSTATUS, OP_READ, '0);
      access(SEL_MIE, OP_WRITE, '1);
      access(SEL_MIE, OP_READ, '0);
      access(SEL_MCAUSE, OP_WRITE, '1);
      access(SEL_MCAUSE, OP_READ, '0);

      // each trap clears MIE and records its cause, mret brings MIE back from MPIE.
      // MIE alternates between set and clear before the trap.
      for (int c = 0; c < 6; c++) begin
         if (c[0]) begin
            access(SEL_MSTATUS, OP_CLR, 32'h8);
         end else begin
            access(SEL_MSTATUS, OP_SET, 32'h8);
         end
         trap(trap_cause_t'(c[2:0]));
         access(SEL_MCAUSE, OP_READ, '0);
         access(SEL_MSTATUS, OP_READ, '0);
         mret();
         access(SEL_MSTATUS, OP_READ, '0);
      end

      // timer interrupt pulses once and only with both enables set.
      access(SEL_MIE, OP_WRITE, 32'h80);
      access(SEL_MSTATUS, OP_WRITE, 32'h8);
      i_mtip = 1'b1;
      check_irq(5, 1);
      check_irq(10, 0);
      i_mtip = 1'b0;
      access(SEL_MSTATUS, OP_CLR, 32'h8);
      i_mtip = 1'b1;
      check_irq(8, 0);
      i_mtip = 1'b0;
      access(SEL_MSTATUS, OP_SET, 32'h8);
      access(SEL_MIE, OP_CLR, 32'h80);
      i_mtip = 1'b1;
      check_irq(8, 0);
      i_mtip = 1'b0;

      // back-to-back commands with i_valid held high while busy.
      hold_valid = 1'b1;
      access(SEL_MSCRATCH, OP_WRITE, rand_bits(32));
      access(SEL_MTVEC, OP_SET, rand_bits(32));
      access(SEL_MEPC, OP_CLR, rand_bits(32));
      hold_valid = 1'b0;
      access(SEL_MTVAL, OP_READ, '0);

      repeat (4) @(posedge i_clk);
      end_run();
   end
endmodule
